//--- build.f
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/ctrl_if.sv
hw/cla_adder.sv
hw/alu.sv
hw/register_file.sv
hw/control_decoder.sv
hw/pc_unit.sv
hw/mips_cpu.sv
dv/tb_mips_cpu.sv

//--- dv/tb_mips_cpu.sv
`default_nettype none

`include "cpu_cfg.svh"

module tb_mips_cpu;
  import isa_pkg::*;

  localparam int    MEM_WORDS  = 64;           // both memory models
  localparam word_t MEM_BYTES  = 32'd256;
  localparam word_t NOP        = '0;           // sll r0, r0, 0
  localparam int    MAX_CYCLES = 600;          // all tests with resets take about 100

  logic  clk;
  logic  reset;
  word_t pc;
  word_t instr;
  logic  dmem_we;
  word_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;

  word_t imem [0:MEM_WORDS-1];
  word_t dmem [0:MEM_WORDS-1];
  word_t prog [$];                             // program being assembled
  word_t pc_log [$];                           // o_pc of each executed instr
  word_t addr_log [$];                         // o_dmem_addr of each executed instr
  word_t st_addr_log [$];
  word_t st_data_log [$];
  word_t exp_pc [$];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];
  integer seed;
  int     cycles;

  mips_cpu DUT (
    .clk          (clk),
    .reset        (reset),
    .o_pc         (pc),
    .i_instr      (instr),
    .o_dmem_we    (dmem_we),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata)
  );

  // ----------------------------------------------------------
  // clock, memory models, monitors
  // ----------------------------------------------------------
  initial clk = 1'b0;
  always #5 clk = ~clk;

  assign instr      = (pc < MEM_BYTES) ? imem[pc[7:2]] : NOP;  // nop past the program
  assign dmem_rdata = (dmem_addr < MEM_BYTES) ? dmem[dmem_addr[7:2]] : '0;

  // combinational outputs settled by mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      pc_log.push_back(pc);
      addr_log.push_back(dmem_addr);
      if (dmem_we) begin
        st_addr_log.push_back(dmem_addr);
        st_data_log.push_back(dmem_wdata);
        if (dmem_addr < MEM_BYTES) begin
          dmem[dmem_addr[7:2]] = dmem_wdata;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      fail_run($sformatf("timeout, tests still running after %0d cycles", MAX_CYCLES));
    end
  end

  // ----------------------------------------------------------
  // reporting and reference rules
  // ----------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    assert (act === exp) else
      fail_run($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, act));
  endtask

  function automatic word_t sext16(input imm16_t v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t zext16(input imm16_t v);
    return {16'h0000, v};
  endfunction

  function automatic word_t sra_ref(input word_t v, input logic [4:0] sh);
    word_t fill;
    fill = v[31] ? ~(32'hffff_ffff >> sh) : '0;  // copies of the sign bit on top
    return (v >> sh) | fill;
  endfunction

  function automatic word_t branch_target(input word_t at, input imm16_t off);
    return at + 32'd4 + (sext16(off) << 2);
  endfunction

  function automatic word_t jump_target(input word_t at, input jaddr_t idx);
    word_t next;
    next = at + 32'd4;
    return {next[31:28], idx, 2'b00};
  endfunction

  // ----------------------------------------------------------
  // assembler with the destination operand first as in assembly
  // ----------------------------------------------------------
  function automatic word_t r_type(input funct_e fn, input reg_addr_t rd, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [4:0] sh);
    return {op_rtype, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t i_type(input opcode_e op, input reg_addr_t rt, input reg_addr_t rs,
                                   input imm16_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_type(input opcode_e op, input jaddr_t idx);
    return {op, idx};
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic emit_li(input reg_addr_t rd, input word_t v);
    emit(i_type(op_lui, rd, 5'd0, v[31:16]));
    emit(i_type(op_ori, rd, rd, v[15:0]));
  endtask

  // sw rt, off(r0) plus the store it must produce
  task automatic emit_store(input reg_addr_t rt, input imm16_t off, input word_t exp_data);
    emit(i_type(op_sw, rt, 5'd0, off));
    exp_st_addr.push_back(sext16(off));
    exp_st_data.push_back(exp_data);
  endtask

  // ----------------------------------------------------------
  // run control
  // ----------------------------------------------------------
  task automatic begin_test();
    prog.delete();
    exp_pc.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
  endtask

  task automatic load_program();
    reset = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : NOP;
      dmem[i] = 32'hd5a0_0000 ^ word_t'(i * 4);  // tagged with its byte address
    end
    pc_log.delete();
    addr_log.delete();
    st_addr_log.delete();
    st_data_log.delete();
  endtask

  task automatic run_program(input int n);
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (n) @(posedge clk);                 // one instruction per edge
    #1;
  endtask

  task automatic check_results(input string name);
    foreach (exp_pc[i]) begin
      check_word($sformatf("%s pc %0d", name, i), exp_pc[i], pc_log[i]);
    end
    check_word({name, " store count"}, word_t'(exp_st_addr.size()),
               word_t'(st_addr_log.size()));
    foreach (exp_st_addr[i]) begin
      check_word($sformatf("%s store %0d addr", name, i), exp_st_addr[i], st_addr_log[i]);
      check_word($sformatf("%s store %0d data", name, i), exp_st_data[i], st_data_log[i]);
    end
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  task automatic test_reset_pc();
    begin_test();
    load_program();                            // empty program of nops
    #2;
    check_word("pc in reset", `CPU_RESET_PC, pc);
    check_word("store strobe in reset", 32'd0, word_t'(dmem_we));
    for (int k = 0; k < 8; k++) begin
      exp_pc.push_back(`CPU_RESET_PC + word_t'(4 * k));
    end
    run_program(8);
    check_results("reset");
  endtask

  task automatic test_alu();
    word_t  a;
    word_t  b;
    word_t  rnd;
    imm16_t imm;
    begin_test();
    a   = $random(seed);
    b   = $random(seed);
    rnd = $random(seed);
    imm = rnd[15:0] | 16'h8000;                // sign and zero extension differ
    emit_li(5'd1, a);
    emit_li(5'd2, b);
    emit(r_type(fn_add, 5'd3, 5'd1, 5'd2, 5'd0));
    emit_store(5'd3, 16'h0010, a + b);
    emit(r_type(fn_sub, 5'd4, 5'd1, 5'd2, 5'd0));
    emit_store(5'd4, 16'h0014, a - b);         // wraps modulo 2**32
    emit(r_type(fn_and, 5'd5, 5'd1, 5'd2, 5'd0));
    emit_store(5'd5, 16'h0018, a & b);
    emit(r_type(fn_or, 5'd6, 5'd1, 5'd2, 5'd0));
    emit_store(5'd6, 16'h001c, a | b);
    emit(r_type(fn_xor, 5'd7, 5'd1, 5'd2, 5'd0));
    emit_store(5'd7, 16'h0020, a ^ b);
    emit(i_type(op_addi, 5'd8, 5'd1, imm));
    emit_store(5'd8, 16'h0024, a + sext16(imm));
    emit(i_type(op_andi, 5'd9, 5'd1, imm));
    emit_store(5'd9, 16'h0028, a & zext16(imm));
    emit(i_type(op_ori, 5'd10, 5'd1, imm));
    emit_store(5'd10, 16'h002c, a | zext16(imm));
    emit(i_type(op_xori, 5'd11, 5'd1, imm));
    emit_store(5'd11, 16'h0030, a ^ zext16(imm));
    emit(i_type(op_lui, 5'd12, 5'd0, imm));
    emit_store(5'd12, 16'h0034, {imm, 16'h0000});
    load_program();
    run_program(prog.size());
    check_results("alu");
  endtask

  task automatic test_shifts();
    word_t      v;
    word_t      rnd;
    logic [4:0] sh_l;
    logic [4:0] sh_r;
    logic [4:0] sh_a;
    begin_test();
    rnd  = $random(seed);
    v    = rnd | 32'h8000_0000;                // negative operand
    rnd  = $random(seed);
    sh_l = rnd[4:0] | 5'd1;                    // nonzero so the three shifts differ
    sh_r = rnd[9:5] | 5'd1;
    sh_a = rnd[14:10] | 5'd1;
    emit_li(5'd1, v);
    emit(r_type(fn_sll, 5'd2, 5'd0, 5'd1, sh_l));
    emit_store(5'd2, 16'h0010, v << sh_l);
    emit(r_type(fn_srl, 5'd3, 5'd0, 5'd1, sh_r));
    emit_store(5'd3, 16'h0014, v >> sh_r);
    emit(r_type(fn_sra, 5'd4, 5'd0, 5'd1, sh_a));
    emit_store(5'd4, 16'h0018, sra_ref(v, sh_a));
    emit(i_type(op_addi, 5'd0, 5'd1, 16'h0005));  // r0 writes are dropped
    emit(r_type(fn_add, 5'd0, 5'd1, 5'd1, 5'd0));
    emit_store(5'd0, 16'h001c, '0);
    load_program();
    run_program(prog.size());
    check_results("shift");
  endtask

  task automatic test_load();
    word_t base;
    word_t ld_addr;
    word_t w;
    begin_test();
    base    = 32'h0000_0080;
    ld_addr = base + sext16(16'hfff8);         // negative offset
    w       = $random(seed);
    emit(i_type(op_addi, 5'd5, 5'd0, base[15:0]));
    emit(i_type(op_lw, 5'd6, 5'd5, 16'hfff8));
    emit(i_type(op_addi, 5'd7, 5'd6, 16'h0001));
    emit(i_type(op_sw, 5'd7, 5'd5, 16'h0004));
    exp_st_addr.push_back(base + sext16(16'h0004));
    exp_st_data.push_back(w + 32'd1);
    load_program();
    dmem[ld_addr[7:2]] = w;
    run_program(prog.size());
    check_word("lw address", ld_addr, addr_log[1]);
    check_results("load");
  endtask

  task automatic test_branches();
    word_t p;
    begin_test();
    emit(i_type(op_addi, 5'd1, 5'd0, 16'h0005));
    emit(i_type(op_addi, 5'd2, 5'd0, 16'h0005));
    emit(i_type(op_addi, 5'd3, 5'd0, 16'h0007));
    emit(i_type(op_beq, 5'd2, 5'd1, 16'h0002));   // taken as r1 == r2
    emit(NOP);
    emit(NOP);
    emit(i_type(op_beq, 5'd3, 5'd1, 16'h0003));   // not taken
    emit(i_type(op_bne, 5'd3, 5'd1, 16'h0001));   // taken
    emit(NOP);
    emit(i_type(op_bne, 5'd2, 5'd1, 16'h0004));   // not taken
    emit(i_type(op_beq, 5'd0, 5'd0, 16'hfffd));   // always taken backwards
    for (int k = 0; k < 4; k++) begin
      exp_pc.push_back(word_t'(4 * k));
    end
    p = branch_target(32'd12, 16'h0002);
    exp_pc.push_back(p);
    p = p + 32'd4;
    exp_pc.push_back(p);
    p = branch_target(p, 16'h0001);
    exp_pc.push_back(p);
    p = p + 32'd4;
    exp_pc.push_back(p);
    p = branch_target(p, 16'hfffd);
    exp_pc.push_back(p);
    exp_pc.push_back(p + 32'd4);
    exp_pc.push_back(p + 32'd8);
    load_program();
    run_program(exp_pc.size());
    check_results("branch");
  endtask

  task automatic test_jumps();
    word_t jal_pc;
    begin_test();
    emit(j_type(op_j, 26'd4));
    emit(NOP);
    emit(NOP);
    emit(NOP);
    emit(j_type(op_jal, 26'd8));                  // r31 <= 20
    emit(i_type(op_sw, 5'd31, 5'd0, 16'h0040));   // reached by jr
    emit(NOP);
    emit(NOP);
    emit(i_type(op_sw, 5'd31, 5'd0, 16'h0044));
    emit(r_type(fn_jr, 5'd0, 5'd31, 5'd0, 5'd0));
    jal_pc = jump_target(32'd0, 26'd4);
    exp_pc.push_back(32'd0);
    exp_pc.push_back(jal_pc);
    exp_pc.push_back(jump_target(jal_pc, 26'd8));
    exp_pc.push_back(jump_target(jal_pc, 26'd8) + 32'd4);
    exp_pc.push_back(jal_pc + 32'd4);             // return address
    exp_pc.push_back(jal_pc + 32'd8);
    exp_st_addr.push_back(32'h0000_0044);          // in execution order
    exp_st_data.push_back(jal_pc + 32'd4);
    exp_st_addr.push_back(32'h0000_0040);
    exp_st_data.push_back(jal_pc + 32'd4);
    load_program();
    run_program(exp_pc.size());
    check_results("jump");
  endtask

  initial begin
    seed   = 32'h1c8a_a701;
    reset  = 1'b1;
    cycles = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = NOP;
      dmem[i] = '0;
    end
    @(posedge clk);
    #1;
    test_reset_pc();
    test_alu();
    test_shifts();
    test_load();
    test_branches();
    test_jumps();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

`include "cpu_cfg.svh"

module alu (
  input  isa_pkg::word_t    i_a,
  input  isa_pkg::word_t    i_b,
  input  ctrl_pkg::alu_op_e i_op,
  output isa_pkg::word_t    o_result,
  output logic              o_zero
);
  import isa_pkg::*;

  logic [3:0]             op_bits;     // raw code, see ctrl_pkg
  logic [`CPU_SHAMT_W-1:0] shamt;
  word_t                  b_in;        // b or ~b for sub
  word_t                  d_addsub;
  word_t                  d_and_or;
  word_t                  d_xor_lui;
  word_t                  d_shift;

  assign op_bits = i_op;

  // ----------------------------------------------------------
  // add / sub: a - b = a + ~b + 1
  // ----------------------------------------------------------
  assign b_in = i_b ^ {`CPU_XLEN{op_bits[2]}};

  cla_adder #(.WIDTH(`CPU_XLEN)) u_addsub (
    .i_a     (i_a),
    .i_b     (b_in),
    .i_carry (op_bits[2]),                  // +1 on sub
    .o_sum   (d_addsub),
    .o_gen   (),
    .o_prop  ()
  );

  assign d_and_or  = op_bits[2] ? (i_a | i_b) : (i_a & i_b);
  assign d_xor_lui = op_bits[2] ? {i_b[15:0], 16'h0000} : (i_a ^ i_b);  // lui uses imm only

  // barrel shifter, b shifted by a[4:0]
  assign shamt = i_a[`CPU_SHAMT_W-1:0];

  always_comb begin
    if (!op_bits[2]) begin
      d_shift = i_b << shamt;               // sll
    end else if (!op_bits[3]) begin
      d_shift = i_b >> shamt;               // srl
    end else begin
      d_shift = $signed(i_b) >>> shamt;     // sra, sign fill
    end
  end

  // four-way result select
  always_comb begin
    case (op_bits[1:0])
      2'b00:   o_result = d_addsub;
      2'b01:   o_result = d_and_or;
      2'b10:   o_result = d_xor_lui;
      default: o_result = d_shift;
    endcase
  end

  assign o_zero = ~|o_result;               // beq/bne compare via xor

endmodule

`default_nettype wire

//--- hw/cla_adder.sv
`default_nettype none

module cla_adder #(
  parameter int WIDTH = 32                     // power of two
) (
  input  logic [WIDTH-1:0] i_a,
  input  logic [WIDTH-1:0] i_b,
  input  logic             i_carry,            // carry into bit 0
  output logic [WIDTH-1:0] o_sum,
  output logic             o_gen,              // group generate
  output logic             o_prop              // group propagate
);

  generate
    if (WIDTH == 1) begin : g_leaf
      // full adder with its own g, p
      assign o_sum  = i_a ^ i_b ^ i_carry;
      assign o_gen  = i_a & i_b;
      assign o_prop = i_a | i_b;
    end else begin : g_node
      localparam int HALF = WIDTH / 2;

      logic gen_lo;
      logic prop_lo;
      logic gen_hi;
      logic prop_hi;
      logic carry_hi;                          // carry into upper half

      cla_adder #(.WIDTH(HALF)) u_lo (
        .i_a     (i_a[HALF-1:0]),
        .i_b     (i_b[HALF-1:0]),
        .i_carry (i_carry),
        .o_sum   (o_sum[HALF-1:0]),
        .o_gen   (gen_lo),
        .o_prop  (prop_lo)
      );

      cla_adder #(.WIDTH(HALF)) u_hi (
        .i_a     (i_a[WIDTH-1:HALF]),
        .i_b     (i_b[WIDTH-1:HALF]),
        .i_carry (carry_hi),
        .o_sum   (o_sum[WIDTH-1:HALF]),
        .o_gen   (gen_hi),
        .o_prop  (prop_hi)
      );

      assign carry_hi = gen_lo | (prop_lo & i_carry);   // lookahead into hi
      assign o_gen    = gen_hi | (prop_hi & gen_lo);    // merged generate
      assign o_prop   = prop_hi & prop_lo;              // merged propagate
    end
  endgenerate

endmodule

`default_nettype wire

//--- hw/control_decoder.sv
`default_nettype none

module control_decoder (
  input  isa_pkg::opcode_e i_opcode,
  input  isa_pkg::funct_e  i_funct,
  ctrl_if.decoder          ctrl
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  always_comb begin
    // ----------------------------------------------------------
    // defaults: no writes, sequential pc
    // ----------------------------------------------------------
    ctrl.alu_ctrl   = alu_add;
    ctrl.alu_imm    = 1'b0;
    ctrl.shift_imm  = 1'b0;
    ctrl.sign_ext   = 1'b0;
    ctrl.dest_sel   = dest_rt;
    ctrl.reg_write  = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.link       = 1'b0;
    ctrl.pc_src     = pc_seq;

    case (i_opcode)
      op_rtype: begin
        ctrl.dest_sel  = dest_rd;
        ctrl.reg_write = 1'b1;                   // cleared for jr / unknown
        ctrl.shift_imm = i_funct inside {fn_sll, fn_srl, fn_sra};
        case (i_funct)
          fn_add:  ctrl.alu_ctrl = alu_add;
          fn_sub:  ctrl.alu_ctrl = alu_sub;
          fn_and:  ctrl.alu_ctrl = alu_and;
          fn_or:   ctrl.alu_ctrl = alu_or;
          fn_xor:  ctrl.alu_ctrl = alu_xor;
          fn_sll:  ctrl.alu_ctrl = alu_sll;
          fn_srl:  ctrl.alu_ctrl = alu_srl;
          fn_sra:  ctrl.alu_ctrl = alu_sra;
          fn_jr: begin
            ctrl.reg_write = 1'b0;
            ctrl.pc_src    = pc_reg;             // target from rs
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      op_addi, op_lw, op_sw: begin
        ctrl.alu_imm    = 1'b1;                  // rs + sext(imm)
        ctrl.sign_ext   = 1'b1;
        ctrl.reg_write  = (i_opcode != op_sw);
        ctrl.mem_to_reg = (i_opcode == op_lw);
        ctrl.mem_write  = (i_opcode == op_sw);
      end
      op_andi, op_ori, op_xori, op_lui: begin
        ctrl.alu_imm   = 1'b1;                   // zero extended imm
        ctrl.reg_write = 1'b1;
        case (i_opcode)
          op_andi: ctrl.alu_ctrl = alu_and;
          op_ori:  ctrl.alu_ctrl = alu_or;
          op_xori: ctrl.alu_ctrl = alu_xor;
          default: ctrl.alu_ctrl = alu_lui;
        endcase
      end
      op_beq, op_bne: begin
        ctrl.alu_ctrl = alu_xor;                 // zero when rs == rt
        ctrl.sign_ext = 1'b1;
        if (ctrl.zero == (i_opcode == op_beq)) begin
          ctrl.pc_src = pc_branch;
        end
      end
      op_j: begin
        ctrl.pc_src = pc_jump;
      end
      op_jal: begin
        ctrl.pc_src    = pc_jump;
        ctrl.dest_sel  = dest_ra;                // r31 <= pc + 4
        ctrl.reg_write = 1'b1;
        ctrl.link      = 1'b1;
      end
      default: begin
        ctrl.pc_src = pc_seq;                    // unknown op acts as nop
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ----------------------------------------------------------
// core widths and sizes
// ----------------------------------------------------------

// datapath word width
`define CPU_XLEN       32

// register index width
`define CPU_REG_ADDR_W 5

// r0..r31, r0 hardwired to zero
`define CPU_NUM_REGS   32

// first fetch address after reset
`define CPU_RESET_PC   32'h0000_0000

// shamt field, also the barrel shifter amount
`define CPU_SHAMT_W    5

`endif

//--- hw/ctrl_if.sv
`default_nettype none

interface ctrl_if;
  import ctrl_pkg::*;

  alu_op_e   alu_ctrl;    // 4-bit alu code
  logic      alu_imm;     // alu b from extended immediate
  logic      shift_imm;   // alu a from shamt field
  logic      sign_ext;    // else zero extend
  dest_sel_e dest_sel;    // rd / rt / r31
  logic      reg_write;   // regfile write enable
  logic      mem_to_reg;  // writeback from load data
  logic      mem_write;   // store strobe
  logic      link;        // writeback pc+4
  pc_src_e   pc_src;      // next pc select, branch resolved
  logic      zero;        // alu result all zero

  modport decoder (
    input  zero,
    output alu_ctrl, alu_imm, shift_imm, sign_ext, dest_sel,
    output reg_write, mem_to_reg, mem_write, link, pc_src
  );

  modport datapath (
    input  alu_ctrl, alu_imm, shift_imm, sign_ext, dest_sel,
    input  reg_write, mem_to_reg, mem_write, link,
    output zero
  );

  modport fetch (
    input  pc_src
  );

endinterface

`default_nettype wire

//--- hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // ----------------------------------------------------------
  // alu code
  // bit 2 picks the second op of each pair (sub/or/lui/right)
  // bit 3 marks arithmetic right shift
  // bits 1:0 pick the result group
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    alu_add = 4'b0000,
    alu_sub = 4'b0100,
    alu_and = 4'b0001,
    alu_or  = 4'b0101,
    alu_xor = 4'b0010,  // also beq/bne compare
    alu_lui = 4'b0110,
    alu_sll = 4'b0011,
    alu_srl = 4'b0111,
    alu_sra = 4'b1111
  } alu_op_e;

  // next pc source
  typedef enum logic [1:0] {
    pc_seq    = 2'b00,  // pc + 4
    pc_branch = 2'b01,  // pc + 4 + (imm << 2)
    pc_reg    = 2'b10,  // rs, for jr
    pc_jump   = 2'b11   // {pc+4[31:28], index, 00}
  } pc_src_e;

  // register file write index
  typedef enum logic [1:0] {
    dest_rd = 2'b00,  // r-type
    dest_rt = 2'b01,  // i-type
    dest_ra = 2'b10   // jal link register r31
  } dest_sel_e;

endpackage

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package isa_pkg;

  typedef logic [`CPU_XLEN-1:0]       word_t;      // one machine word
  typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;  // rs / rt / rd index
  typedef logic [15:0]                imm16_t;     // i-type immediate
  typedef logic [25:0]                jaddr_t;     // j-type word index

  // ----------------------------------------------------------
  // primary opcodes, instr[31:26]
  // ----------------------------------------------------------
  typedef enum logic [5:0] {
    op_rtype = 6'b000000,  // decoded further by funct
    op_j     = 6'b000010,
    op_jal   = 6'b000011,
    op_beq   = 6'b000100,
    op_bne   = 6'b000101,
    op_addi  = 6'b001000,
    op_andi  = 6'b001100,
    op_ori   = 6'b001101,
    op_xori  = 6'b001110,
    op_lui   = 6'b001111,
    op_lw    = 6'b100011,
    op_sw    = 6'b101011
  } opcode_e;

  // r-type funct codes, instr[5:0]
  typedef enum logic [5:0] {
    fn_add = 6'b100000,
    fn_sub = 6'b100010,
    fn_and = 6'b100100,
    fn_or  = 6'b100101,
    fn_xor = 6'b100110,
    fn_sll = 6'b000000,  // all-zero word is sll r0 -> nop
    fn_srl = 6'b000010,
    fn_sra = 6'b000011,
    fn_jr  = 6'b001000
  } funct_e;

endpackage

`default_nettype wire

//--- hw/mips_cpu.sv
`default_nettype none

`include "cpu_cfg.svh"

module mips_cpu (
  input  logic           clk,
  input  logic           reset,
  output isa_pkg::word_t o_pc,           // fetch address
  input  isa_pkg::word_t i_instr,        // instruction at o_pc
  output logic           o_dmem_we,      // store strobe
  output isa_pkg::word_t o_dmem_addr,
  output isa_pkg::word_t o_dmem_wdata,
  input  isa_pkg::word_t i_dmem_rdata    // load data, same cycle
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  opcode_e                 opcode;
  funct_e                  funct;
  reg_addr_t               rs;
  reg_addr_t               rt;
  reg_addr_t               rd;
  reg_addr_t               dest;          // regfile write index
  logic [`CPU_SHAMT_W-1:0] shamt;
  imm16_t                  imm;
  jaddr_t                  jaddr;
  word_t                   imm_ext;
  word_t                   rs_data;
  word_t                   rt_data;
  word_t                   alu_a;
  word_t                   alu_b;
  word_t                   alu_result;
  word_t                   wb_data;
  word_t                   pc_plus4;

  ctrl_if ctrl ();

  // ----------------------------------------------------------
  // instruction fields
  // ----------------------------------------------------------
  assign opcode = opcode_e'(i_instr[31:26]);
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];
  assign rd     = i_instr[15:11];
  assign shamt  = i_instr[10:6];
  assign funct  = funct_e'(i_instr[5:0]);
  assign imm    = i_instr[15:0];
  assign jaddr  = i_instr[25:0];

  assign imm_ext = {{(`CPU_XLEN-16){ctrl.sign_ext & imm[15]}}, imm};

  control_decoder u_decoder (
    .i_opcode (opcode),
    .i_funct  (funct),
    .ctrl     (ctrl)
  );

  // ----------------------------------------------------------
  // register file, operand select, alu
  // ----------------------------------------------------------
  always_comb begin
    case (ctrl.dest_sel)
      dest_rt: dest = rt;
      dest_ra: dest = reg_addr_t'(`CPU_NUM_REGS - 1);  // r31
      default: dest = rd;
    endcase
  end

  assign wb_data = ctrl.link       ? pc_plus4     :
                   ctrl.mem_to_reg ? i_dmem_rdata : alu_result;

  register_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .i_we     (ctrl.reg_write),
    .i_raddr1 (rs),
    .i_raddr2 (rt),
    .i_waddr  (dest),
    .i_wdata  (wb_data),
    .o_rdata1 (rs_data),
    .o_rdata2 (rt_data)
  );

  assign alu_a = ctrl.shift_imm ? {{(`CPU_XLEN-`CPU_SHAMT_W){1'b0}}, shamt} : rs_data;
  assign alu_b = ctrl.alu_imm   ? imm_ext : rt_data;

  alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (ctrl.alu_ctrl),
    .o_result (alu_result),
    .o_zero   (ctrl.zero)             // back to decoder for branches
  );

  pc_unit u_pc (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl),
    .i_imm_ext    (imm_ext),
    .i_jaddr      (jaddr),
    .i_reg_target (rs_data),
    .o_pc         (o_pc),
    .o_pc_plus4   (pc_plus4)
  );

  // data port, combinational
  assign o_dmem_we    = ctrl.mem_write;
  assign o_dmem_addr  = alu_result;   // base + sext(offset)
  assign o_dmem_wdata = rt_data;

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
`default_nettype none

`include "cpu_cfg.svh"

module pc_unit (
  input  logic            clk,
  input  logic            reset,
  ctrl_if.fetch           ctrl,
  input  isa_pkg::word_t  i_imm_ext,      // extended branch offset
  input  isa_pkg::jaddr_t i_jaddr,        // j / jal word index
  input  isa_pkg::word_t  i_reg_target,   // rs data for jr
  output isa_pkg::word_t  o_pc,
  output isa_pkg::word_t  o_pc_plus4
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  word_t pc_q;
  word_t pc_next;
  word_t branch_target;
  word_t jump_target;

  // ----------------------------------------------------------
  // candidate targets
  // ----------------------------------------------------------
  assign o_pc_plus4    = pc_q + word_t'(4);
  assign branch_target = o_pc_plus4 + {i_imm_ext[`CPU_XLEN-3:0], 2'b00};  // word offset
  assign jump_target   = {o_pc_plus4[`CPU_XLEN-1:`CPU_XLEN-4], i_jaddr, 2'b00};

  always_comb begin
    case (ctrl.pc_src)
      pc_branch: pc_next = branch_target;
      pc_reg:    pc_next = i_reg_target;
      pc_jump:   pc_next = jump_target;
      default:   pc_next = o_pc_plus4;    // pc_seq
    endcase
  end

  // pc register, one instruction per edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc_q <= `CPU_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

`include "cpu_cfg.svh"

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               i_we,
  input  isa_pkg::reg_addr_t i_raddr1,
  input  isa_pkg::reg_addr_t i_raddr2,
  input  isa_pkg::reg_addr_t i_waddr,
  input  isa_pkg::word_t     i_wdata,
  output isa_pkg::word_t     o_rdata1,
  output isa_pkg::word_t     o_rdata2
);
  import isa_pkg::*;

  word_t regs [1:`CPU_NUM_REGS-1];    // no storage for r0

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 1; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;                // known state at program start
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;       // writes to r0 dropped
    end
  end

  // combinational reads, r0 forced to zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile with Verilator, run the testbench, decide from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_mips_cpu \
  -o tb_sim && ./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "All tests passed!" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
